// File: Bender.yml
package:
  name: gat_attn

sources:
  - gat_attn_pkg.sv
  - attn_coef_unit.sv
  - coef_fifo.sv
  - subgraph_stats_unit.sv
  - gat_attn_top.sv
  - target: test
    files:
      - gat_attn_checker.sv
      - tb_gat_attn.sv

// File: attn_coef_unit.sv
`timescale 1ns/100ps
`default_nettype none

module attn_coef_unit import gat_attn_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,

  input  logic        a_load_i,
  input  a_vec_t      a_vec_i,

  input  logic        in_valid_i,
  input  wh_beat_t    in_beat_i,
  output logic        in_ready_o,

  input  logic        fifo_full_i,
  output logic        coef_wr_o,
  output coef_entry_t coef_entry_o
);

  a_vec_t                    a_reg;

  logic                      advance;
  logic                      s1_valid;
  logic                      s2_valid;
  logic                      s3_valid;

  logic                      s1_first;
  logic                      s1_last;
  logic signed [PROD_W-1:0]  s1_prod_src [NUM_FEAT];
  logic signed [PROD_W-1:0]  s1_prod_nbr [NUM_FEAT];

  logic signed [DOT_W-1:0]   dot_src;
  logic signed [DOT_W-1:0]   dot_nbr;
  logic signed [DOT_W-1:0]   tgt_term;
  logic signed [DOT_W-1:0]   s2_tgt;
  logic signed [DOT_W-1:0]   s2_nbr;
  logic                      s2_last;

  logic signed [SCORE_W-1:0] score;
  logic signed [SCORE_W-1:0] leaky;
  logic signed [SCORE_W-1:0] scaled;
  logic signed [COEF_W-1:0]  coef_sat;
  coef_entry_t               s3_entry;

  // Whole pipe freezes only when the last stage cannot drain
  assign advance      = !(s3_valid && fifo_full_i);
  assign in_ready_o   = advance;
  assign coef_wr_o    = s3_valid && !fifo_full_i;
  assign coef_entry_o = s3_entry;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      a_reg <= '0;
    end else if (a_load_i) begin
      a_reg <= a_vec_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
      s3_valid <= 1'b0;
    end else if (advance) begin
      s1_valid <= in_valid_i;
      s2_valid <= s1_valid;
      s3_valid <= s2_valid;
    end
  end

  // Stage 1 element-wise products
  always_ff @(posedge clk) begin
    if (advance) begin
      s1_first <= in_beat_i.first;
      s1_last  <= in_beat_i.last;
      for (int i = 0; i < NUM_FEAT; i++) begin
        s1_prod_src[i] <= $signed(a_reg[i]) * $signed(in_beat_i.wh[i]);
        s1_prod_nbr[i] <= $signed(a_reg[NUM_FEAT+i]) * $signed(in_beat_i.wh[i]);
      end
    end
  end

  always_comb begin
    dot_src = '0;
    dot_nbr = '0;
    for (int i = 0; i < NUM_FEAT; i++) begin
      dot_src = dot_src + s1_prod_src[i];
      dot_nbr = dot_nbr + s1_prod_nbr[i];
    end
  end

  // Target node sets the source term for its whole subgraph
  always_ff @(posedge clk) begin
    if (advance) begin
      s2_tgt  <= s1_first ? dot_src : tgt_term;
      s2_nbr  <= dot_nbr;
      s2_last <= s1_last;
      if (s1_valid && s1_first) begin
        tgt_term <= dot_src;
      end
    end
  end

  // LeakyReLU with slope 1/4 then rescale and clamp
  always_comb begin
    score  = s2_tgt + s2_nbr;
    leaky  = score[SCORE_W-1] ? (score >>> 2) : score;
    scaled = leaky >>> COEF_SHIFT;
    if (scaled > COEF_MAX) begin
      coef_sat = COEF_W'(COEF_MAX);
    end else if (scaled < COEF_MIN) begin
      coef_sat = COEF_W'(COEF_MIN);
    end else begin
      coef_sat = scaled[COEF_W-1:0];
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      s3_entry.coef <= coef_sat;
      s3_entry.last <= s2_last;
    end
  end

endmodule

`default_nettype wire

// File: coef_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module coef_fifo import gat_attn_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,

  input  logic        wr_en_i,
  input  coef_entry_t wr_entry_i,
  output logic        full_o,

  input  logic        rd_en_i,
  output coef_entry_t rd_entry_o,
  output logic        empty_o
);

  coef_entry_t        mem [FIFO_DEPTH];
  logic [FIFO_AW-1:0] wr_ptr;
  logic [FIFO_AW-1:0] rd_ptr;
  logic [FIFO_AW:0]   count;
  logic               do_wr;
  logic               do_rd;

  assign full_o  = (count == (FIFO_AW+1)'(FIFO_DEPTH));
  assign empty_o = (count == '0);
  assign do_wr   = wr_en_i && !full_o;
  assign do_rd   = rd_en_i && !empty_o;

  // Head entry shown directly
  assign rd_entry_o = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= wr_entry_i;
    end
  end

  // Pointers wrap naturally since depth is a power of two
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: gat_attn.f
gat_attn_pkg.sv
attn_coef_unit.sv
coef_fifo.sv
subgraph_stats_unit.sv
gat_attn_top.sv
gat_attn_checker.sv
tb_gat_attn.sv

// File: gat_attn_checker.sv
`timescale 1ns/100ps
`default_nettype none

module gat_attn_checker import gat_attn_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      in_valid_i,
  input  wh_beat_t  in_beat_i,
  input  logic      in_ready_o,
  input  logic      out_valid_o,
  input  logic      out_ready_i,
  input  sg_stats_t out_stats_o
);

  // Assertion failures so far
  int err_cnt = 0;

  // Source must hold a stalled beat
  in_stable: assert property (@(posedge clk) disable iff (!rst_n)
    in_valid_i && !in_ready_o |=> in_valid_i && $stable(in_beat_i))
    else begin
      $error("input beat changed while stalled");
      err_cnt++;
    end

  // Held result must not change until taken
  out_stable: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_stats_o))
    else begin
      $error("output stats changed while held");
      err_cnt++;
    end

  count_range: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid_o |-> (out_stats_o.count >= 1) && (out_stats_o.count <= MAX_NODES))
    else begin
      $error("output node count out of range");
      err_cnt++;
    end

endmodule

bind gat_attn_top gat_attn_checker u_checker (.*);

`default_nettype wire

// File: gat_attn_pkg.sv
`default_nettype none

package gat_attn_pkg;

  // Datapath widths
  localparam int NUM_FEAT   = 4;
  localparam int WH_W       = 12;
  localparam int A_W        = 8;
  localparam int PROD_W     = WH_W + A_W;
  localparam int DOT_W      = PROD_W + 2;
  localparam int SCORE_W    = DOT_W + 1;

  // Coefficient rescale and clamp range
  localparam int COEF_W     = 8;
  localparam int COEF_SHIFT = 8;
  localparam int COEF_MAX   = 2**(COEF_W-1) - 1;
  localparam int COEF_MIN   = -(2**(COEF_W-1));

  // Subgraph limits with the target node included
  localparam int MAX_NODES  = 16;
  localparam int CNT_W      = $clog2(MAX_NODES + 1);
  localparam int SUM_W      = 12;

  localparam int FIFO_DEPTH = 16;
  localparam int FIFO_AW    = $clog2(FIFO_DEPTH);

  typedef logic signed [WH_W-1:0] wh_elem_t;
  typedef logic signed [A_W-1:0]  a_elem_t;

  typedef wh_elem_t [NUM_FEAT-1:0]   wh_vec_t;
  // Lower half is a_src, upper half a_nbr
  typedef a_elem_t  [2*NUM_FEAT-1:0] a_vec_t;

  typedef struct packed {
    wh_vec_t wh;
    logic    first;
    logic    last;
  } wh_beat_t;

  typedef struct packed {
    logic signed [COEF_W-1:0] coef;
    logic                     last;
  } coef_entry_t;

  typedef struct packed {
    logic signed [COEF_W-1:0] max_coef;
    logic signed [SUM_W-1:0]  sum;
    logic [CNT_W-1:0]         count;
  } sg_stats_t;

  typedef enum logic [0:0] {
    ST_ACCUM,
    ST_HOLD
  } stats_state_t;

endpackage

`default_nettype wire

// File: gat_attn_top.sv
`timescale 1ns/100ps
`default_nettype none

module gat_attn_top import gat_attn_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,

  input  logic      a_load_i,
  input  a_vec_t    a_vec_i,

  input  logic      in_valid_i,
  input  wh_beat_t  in_beat_i,
  output logic      in_ready_o,

  output logic      out_valid_o,
  input  logic      out_ready_i,
  output sg_stats_t out_stats_o
);

  logic        coef_wr;
  logic        coef_rd;
  logic        fifo_full;
  logic        fifo_empty;
  coef_entry_t wr_entry;
  coef_entry_t rd_entry;

  attn_coef_unit u_attn_coef_unit (
    .clk          (clk          ),
    .rst_n        (rst_n        ),
    .a_load_i     (a_load_i     ),
    .a_vec_i      (a_vec_i      ),
    .in_valid_i   (in_valid_i   ),
    .in_beat_i    (in_beat_i    ),
    .in_ready_o   (in_ready_o   ),
    .fifo_full_i  (fifo_full    ),
    .coef_wr_o    (coef_wr      ),
    .coef_entry_o (wr_entry     )
  );

  coef_fifo u_coef_fifo (
    .clk          (clk          ),
    .rst_n        (rst_n        ),
    .wr_en_i      (coef_wr      ),
    .wr_entry_i   (wr_entry     ),
    .full_o       (fifo_full    ),
    .rd_en_i      (coef_rd      ),
    .rd_entry_o   (rd_entry     ),
    .empty_o      (fifo_empty   )
  );

  subgraph_stats_unit u_subgraph_stats_unit (
    .clk          (clk          ),
    .rst_n        (rst_n        ),
    .fifo_empty_i (fifo_empty   ),
    .fifo_entry_i (rd_entry     ),
    .fifo_rd_o    (coef_rd      ),
    .out_valid_o  (out_valid_o  ),
    .out_ready_i  (out_ready_i  ),
    .out_stats_o  (out_stats_o  )
  );

endmodule

`default_nettype wire

// File: subgraph_stats_unit.sv
`timescale 1ns/100ps
`default_nettype none

module subgraph_stats_unit import gat_attn_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,

  input  logic        fifo_empty_i,
  input  coef_entry_t fifo_entry_i,
  output logic        fifo_rd_o,

  output logic        out_valid_o,
  input  logic        out_ready_i,
  output sg_stats_t   out_stats_o
);

  stats_state_t             state;
  logic signed [COEF_W-1:0] acc_max;
  logic signed [SUM_W-1:0]  acc_sum;
  logic [CNT_W-1:0]         acc_cnt;
  logic signed [COEF_W-1:0] coef;
  logic                     pop;
  logic                     fresh;

  assign coef  = fifo_entry_i.coef;
  assign pop   = (state == ST_ACCUM) && !fifo_empty_i;
  // Zero count marks the start of a new subgraph
  assign fresh = (acc_cnt == '0);

  assign fifo_rd_o            = pop;
  assign out_valid_o          = (state == ST_HOLD);
  assign out_stats_o.max_coef = acc_max;
  assign out_stats_o.sum      = acc_sum;
  assign out_stats_o.count    = acc_cnt;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= ST_ACCUM;
      acc_cnt <= '0;
    end else begin
      case (state)
        ST_ACCUM: begin
          if (pop) begin
            acc_cnt <= acc_cnt + 1'b1;
            if (fifo_entry_i.last) begin
              state <= ST_HOLD;
            end
          end
        end
        ST_HOLD: begin
          if (out_ready_i) begin
            state   <= ST_ACCUM;
            acc_cnt <= '0;
          end
        end
        default: state <= ST_ACCUM;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (pop) begin
      if (fresh || (coef > acc_max)) begin
        acc_max <= coef;
      end
      acc_sum <= fresh ? SUM_W'(coef) : acc_sum + coef;
    end
  end

endmodule

`default_nettype wire

// File: tb_gat_attn.sv
`timescale 1ns/100ps
`default_nettype none

module tb_gat_attn import gat_attn_pkg::*; ();

  localparam int TIMEOUT_CYC = 500;

  logic      clk = 1'b0;
  logic      rst_n;
  logic      a_load;
  a_vec_t    a_vec;
  logic      in_valid;
  wh_beat_t  in_beat;
  logic      in_ready;
  logic      out_valid;
  logic      out_ready;
  sg_stats_t out_stats;

  a_vec_t    cur_a;
  wh_vec_t   nodes_q[$];
  sg_stats_t expected_q[$];
  int        sent_cnt = 0;
  int        recv_cnt = 0;

  gat_attn_top uut (
    .clk         (clk      ),
    .rst_n       (rst_n    ),
    .a_load_i    (a_load   ),
    .a_vec_i     (a_vec    ),
    .in_valid_i  (in_valid ),
    .in_beat_i   (in_beat  ),
    .in_ready_o  (in_ready ),
    .out_valid_o (out_valid),
    .out_ready_i (out_ready),
    .out_stats_o (out_stats)
  );

  always #50 clk = ~clk;

  task automatic check_val(input string name, input int exp_v, input int act_v);
    assert (exp_v == act_v) else begin
      $display("MISMATCH %s expected %h actual %h", name, exp_v, act_v);
      $display("SIMULATION FAILED");
      $fatal(1, "value check failed");
    end
  endtask

  task automatic timeout_fail(input string what);
    $display("Timeout after %0d cycles waiting for %s", TIMEOUT_CYC, what);
    $display("SIMULATION FAILED");
    $fatal(1, "wait timed out");
  endtask

  // Score from target and neighbour through LeakyReLU, rescale and clamp
  function automatic int coef_model(input a_vec_t a, input wh_vec_t tgt, input wh_vec_t nbr);
    int score;
    score = 0;
    for (int i = 0; i < NUM_FEAT; i++) begin
      score += int'($signed(a[i])) * int'($signed(tgt[i]));
      score += int'($signed(a[NUM_FEAT+i])) * int'($signed(nbr[i]));
    end
    if (score < 0) begin
      score = score >>> 2;
    end
    score = score >>> COEF_SHIFT;
    if (score > COEF_MAX) begin
      score = COEF_MAX;
    end else if (score < COEF_MIN) begin
      score = COEF_MIN;
    end
    return score;
  endfunction

  function automatic wh_vec_t mk_wh(input int e0, input int e1, input int e2, input int e3);
    wh_vec_t v;
    v[0] = wh_elem_t'(e0);
    v[1] = wh_elem_t'(e1);
    v[2] = wh_elem_t'(e2);
    v[3] = wh_elem_t'(e3);
    return v;
  endfunction

  task automatic fill_random(input int n);
    wh_vec_t v;
    nodes_q.delete();
    repeat (n) begin
      for (int i = 0; i < NUM_FEAT; i++) begin
        v[i] = wh_elem_t'($urandom);
      end
      nodes_q.push_back(v);
    end
  endtask

  task automatic expect_model();
    sg_stats_t s;
    int        c;
    int        mx;
    int        sm;
    mx = COEF_MIN;
    sm = 0;
    foreach (nodes_q[k]) begin
      c = coef_model(cur_a, nodes_q[0], nodes_q[k]);
      if (c > mx) begin
        mx = c;
      end
      sm += c;
    end
    s.max_coef = COEF_W'(mx);
    s.sum      = SUM_W'(sm);
    s.count    = CNT_W'(nodes_q.size());
    expected_q.push_back(s);
  endtask

  // Starts and ends 1 ns after a rising edge
  task automatic send_beat(input wh_beat_t beat);
    int waited;
    waited   = 0;
    in_valid = 1'b1;
    in_beat  = beat;
    @(negedge clk);
    while (!in_ready) begin
      waited++;
      if (waited > TIMEOUT_CYC) begin
        timeout_fail("in_ready_o to accept a beat");
      end
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    in_valid = 1'b0;
  endtask

  task automatic send_nodes();
    wh_beat_t beat;
    for (int k = 0; k < nodes_q.size(); k++) begin
      beat.wh    = nodes_q[k];
      beat.first = (k == 0);
      beat.last  = (k == nodes_q.size() - 1);
      send_beat(beat);
    end
    sent_cnt++;
  endtask

  task automatic load_vec(input a_vec_t a);
    a_vec  = a;
    a_load = 1'b1;
    cur_a  = a;
    @(posedge clk);
    #1;
    a_load = 1'b0;
  endtask

  function automatic a_vec_t random_vec();
    a_vec_t a;
    for (int i = 0; i < 2*NUM_FEAT; i++) begin
      a[i] = a_elem_t'(int'($urandom % 32) - 16);
    end
    return a;
  endfunction

  task automatic wait_drained();
    int waited;
    waited = 0;
    @(posedge clk);
    while (expected_q.size() != 0) begin
      waited++;
      if (waited > TIMEOUT_CYC) begin
        timeout_fail("all expected results to arrive");
      end
      @(posedge clk);
    end
    #1;
  endtask

  // Results are taken where valid and ready meet
  always @(negedge clk) begin : monitor
    sg_stats_t exp_s;
    if (rst_n && out_valid && out_ready) begin
      assert (expected_q.size() > 0) else begin
        $display("A result arrived while none was expected");
        $display("SIMULATION FAILED");
        $fatal(1, "unexpected result");
      end
      exp_s = expected_q.pop_front();
      check_val("out_stats_o.max_coef", exp_s.max_coef, out_stats.max_coef);
      check_val("out_stats_o.sum", exp_s.sum, out_stats.sum);
      check_val("out_stats_o.count", exp_s.count, out_stats.count);
      recv_cnt++;
    end
  end

  // Concurrent assertion failures in the bound checker
  always @(negedge clk) begin : checker_watch
    assert (uut.u_checker.err_cnt == 0) else begin
      $display("Handshake checker reported an assertion failure");
      $display("SIMULATION FAILED");
      $fatal(1, "checker failure");
    end
  end

  task automatic reset_values();
    @(negedge clk);
    check_val("in_ready_o", 1, in_ready);
    check_val("out_valid_o", 0, out_valid);
    @(posedge clk);
    #1;
  endtask

  task automatic known_subgraph();
    a_vec_t    a;
    sg_stats_t s;
    a    = '0;
    a[0] = 8'sd16;
    a[5] = 8'sd127;
    a[6] = 8'sd127;
    a[7] = 8'sd127;
    load_vec(a);
    nodes_q.delete();
    nodes_q.push_back(mk_wh(100, 0, 0, 0));
    // Clamps to 127
    nodes_q.push_back(mk_wh(0, 2047, 0, 0));
    // Clamps to -128
    nodes_q.push_back(mk_wh(0, -2048, -2048, -2048));
    nodes_q.push_back(mk_wh(0, -100, 0, 0));
    nodes_q.push_back(mk_wh(0, 20, 0, 0));
    // Coefficients 6, 127, -128, -11, 16
    s.max_coef = 8'sd127;
    s.sum      = 12'sd10;
    s.count    = 5;
    expected_q.push_back(s);
    send_nodes();
    wait_drained();
  endtask

  task automatic random_stream();
    load_vec(random_vec());
    repeat (20) begin
      fill_random(1 + int'($urandom % MAX_NODES));
      expect_model();
      send_nodes();
    end
    wait_drained();
  endtask

  task automatic output_backpressure();
    sg_stats_t held;
    int        waited;
    int        sizes[3];
    sizes     = '{4, 16, 16};
    waited    = 0;
    out_ready = 1'b0;
    fork
      begin
        foreach (sizes[k]) begin
          fill_random(sizes[k]);
          expect_model();
          send_nodes();
        end
      end
      begin
        @(negedge clk);
        while (in_ready) begin
          waited++;
          if (waited > TIMEOUT_CYC) begin
            timeout_fail("in_ready_o to drop under back-pressure");
          end
          @(negedge clk);
        end
        check_val("out_valid_o", 1, out_valid);
        held = out_stats;
        repeat (4) begin
          @(negedge clk);
          check_val("out_stats_o", int'(held), int'(out_stats));
        end
        @(posedge clk);
        #1;
        out_ready = 1'b1;
      end
    join
    wait_drained();
  endtask

  task automatic vector_reload();
    repeat (2) begin
      load_vec(random_vec());
      repeat (3) begin
        fill_random(1 + int'($urandom % MAX_NODES));
        expect_model();
        send_nodes();
      end
      wait_drained();
    end
  endtask

  initial begin
    void'($urandom(68));
    rst_n     = 1'b0;
    a_load    = 1'b0;
    a_vec     = '0;
    in_valid  = 1'b0;
    in_beat   = '0;
    out_ready = 1'b1;
    cur_a     = '0;
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;

    reset_values();
    known_subgraph();
    random_stream();
    output_backpressure();
    vector_reload();

    check_val("result count", sent_cnt, recv_cnt);
    if (uut.u_checker.err_cnt == 0) begin
      $display("SIMULATION PASSED");
      $finish;
    end else begin
      $display("Handshake checker reported %0d failures", uut.u_checker.err_cnt);
      $display("SIMULATION FAILED");
      $fatal(1, "checker failures");
    end
  end

endmodule

`default_nettype wire
